//--- source/pifBridge_cfg.svh
`ifndef PIF_BRIDGE_CFG_SVH
`define PIF_BRIDGE_CFG_SVH

// --------------------
// receive byte layout
// --------------------

// payload bits below the tag
`define PIF_DATA_BITS 6
`define PIF_TAG_BITS  2

// tag codes in the top bits of a received byte
`define PIF_TAG_ADDR  2'b10
`define PIF_TAG_DATA  2'b01

// --------------------
// parallel port
// --------------------

// register address taken from the low payload bits
`define PIF_ADDR_W    4

// read sub-address counter
`define PIF_SUBA_W    3
`define PIF_SUBA_MAX  5

// --------------------
// slave block registers
// --------------------

// command, transmit, status and receive registers
`define REG_CMDR      8'h41
`define REG_TXDR      8'h44
`define REG_SR        8'h45
`define REG_RXDR      8'h47

// command bytes, bit 2 disables clock stretching
`define CMD_CLKSTR_DIS 8'h04
`define CMD_CLKSTR_EN  8'h00

`endif

//--- source/pifPkg.sv
`default_nettype none

`include "pifBridge_cfg.svh"

package pifPkg;

    // status register, msb first
    typedef struct packed {
        logic tip;
        logic busy;
        logic rarc;
        logic srw;
        logic arbl;
        logic trrdy;
        logic troe;
        logic hgc;
    } i2cStatus_t;

    // tag and payload view of a received byte
    typedef struct packed {
        logic [`PIF_TAG_BITS-1:0]  tag;
        logic [`PIF_DATA_BITS-1:0] payload;
    } rxFields_t;

    typedef union packed {
        logic [7:0] raw;
        rxFields_t  f;
    } rxByte_t;

    // sequencer states
    typedef enum logic [3:0] {
        stStart  = 4'd0,
        stInit1  = 4'd1,
        stInit2  = 4'd2,
        stInit3  = 4'd3,
        stInit4  = 4'd4,
        stIdle   = 4'd5,
        stWaitTr = 4'd6,
        stIn0    = 4'd7,
        stOut0   = 4'd8,
        stOut1   = 4'd9,
        stWr     = 4'd10,
        stRd     = 4'd11
    } seqState_t;

    // single bus cycle request, go is a one-cycle pulse
    typedef struct packed {
        logic       go;
        logic       we;
        logic [7:0] adr;
        logic [7:0] wdat;
    } wbReq_t;

    // strobes towards the parallel port
    typedef struct packed {
        logic                      loadAddr;
        logic                      writeData;
        logic                      readDone;
        logic [`PIF_DATA_BITS-1:0] payload;
    } pifCmd_t;

endpackage

`default_nettype wire

//--- source/wbCycleEngine.sv
`timescale 1ns/1ps
`default_nettype none

module wbCycleEngine (
    input  wire            xclk,
    input  wire            sys_rst,
    input  pifPkg::wbReq_t req_i,
    input  wire            wbAck_i,
    input  wire [7:0]      wbDat_i,
    output logic           wbCyc_o,
    output logic           wbStb_o,
    output logic           wbWe_o,
    output logic [7:0]     wbAdr_o,
    output logic [7:0]     wbDat_o,
    output logic           done_o,
    output logic [7:0]     rdata_o
);

    // --------------------
    // bus cycle
    // --------------------

    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            wbCyc_o <= 1'b0;
            wbStb_o <= 1'b0;
            wbWe_o  <= 1'b0;
            wbAdr_o <= 8'h00;
            wbDat_o <= 8'h00;
            done_o  <= 1'b0;
            rdata_o <= 8'h00;
        end else begin
            done_o <= 1'b0;
            if (wbCyc_o) begin
                // hold until the slave acks, then drop at this edge
                if (wbAck_i) begin
                    wbCyc_o <= 1'b0;
                    wbStb_o <= 1'b0;
                    wbWe_o  <= 1'b0;
                    done_o  <= 1'b1;
                    if (!wbWe_o) begin
                        rdata_o <= wbDat_i;
                    end
                end
            end else if (req_i.go) begin
                // open a new cycle
                wbCyc_o <= 1'b1;
                wbStb_o <= 1'b1;
                wbWe_o  <= req_i.we;
                wbAdr_o <= req_i.adr;
                wbDat_o <= req_i.wdat;
            end
        end
    end

    // --------------------
    // checks
    // --------------------

    // ack only answers an open cycle
    ackInsideCyc: assert property (
        @(posedge xclk) disable iff (!sys_rst)
        wbAck_i |-> wbCyc_o
    );

    // the requester waits for done before the next go
    noReqWhileOpen: assert property (
        @(posedge xclk) disable iff (!sys_rst)
        req_i.go |-> !wbCyc_o
    );

endmodule

`default_nettype wire

//--- source/efbSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pifBridge_cfg.svh"

module efbSequencer (
    input  wire             xclk,
    input  wire             sys_rst,
    input  wire             done_i,
    input  wire [7:0]       rdata_i,
    input  wire [7:0]       xo_i,
    output pifPkg::wbReq_t  req_o,
    output pifPkg::pifCmd_t cmd_o
);

    pifPkg::seqState_t  state;
    pifPkg::seqState_t  nextState;
    pifPkg::seqState_t  retState;
    pifPkg::seqState_t  nextRet;
    pifPkg::i2cStatus_t status;
    pifPkg::rxByte_t    rxByte;

    logic busy;
    logic txReady;
    logic rxReady;
    logic lastNak;
    // last read went to the status register
    logic rdIsStatus;

    function automatic pifPkg::wbReq_t rdReq(input logic [7:0] adr);
        pifPkg::wbReq_t r;
        r     = '0;
        r.go  = 1'b1;
        r.adr = adr;
        return r;
    endfunction

    function automatic pifPkg::wbReq_t wrReq(input logic [7:0] adr, input logic [7:0] dat);
        pifPkg::wbReq_t r;
        r      = '0;
        r.go   = 1'b1;
        r.we   = 1'b1;
        r.adr  = adr;
        r.wdat = dat;
        return r;
    endfunction

    assign status = pifPkg::i2cStatus_t'(rdata_i);

    // --------------------
    // next state and requests
    // --------------------

    always_comb begin
        nextState = state;
        nextRet   = retState;
        req_o     = '0;
        cmd_o     = '0;
        case (state)
            pifPkg::stStart: begin
                req_o     = wrReq(`REG_CMDR, `CMD_CLKSTR_DIS);
                nextRet   = pifPkg::stInit1;
                nextState = pifPkg::stWr;
            end
            pifPkg::stInit1: begin
                req_o     = rdReq(`REG_SR);
                nextRet   = pifPkg::stInit2;
                nextState = pifPkg::stRd;
            end
            pifPkg::stInit2: begin
                // poll status until the bus is free, then flush rx
                if (busy) begin
                    req_o   = rdReq(`REG_SR);
                    nextRet = pifPkg::stInit2;
                end else begin
                    req_o   = rdReq(`REG_RXDR);
                    nextRet = pifPkg::stInit3;
                end
                nextState = pifPkg::stRd;
            end
            pifPkg::stInit3: begin
                req_o     = rdReq(`REG_RXDR);
                nextRet   = pifPkg::stInit4;
                nextState = pifPkg::stRd;
            end
            pifPkg::stInit4: begin
                req_o     = wrReq(`REG_CMDR, `CMD_CLKSTR_EN);
                nextRet   = pifPkg::stIdle;
                nextState = pifPkg::stWr;
            end
            pifPkg::stIdle: begin
                req_o     = rdReq(`REG_SR);
                nextRet   = busy ? pifPkg::stWaitTr : pifPkg::stIdle;
                nextState = pifPkg::stRd;
            end
            pifPkg::stWaitTr: begin
                if (lastNak) begin
                    nextState = pifPkg::stStart;
                end else if (txReady) begin
                    req_o     = wrReq(`REG_TXDR, xo_i);
                    nextRet   = pifPkg::stOut0;
                    nextState = pifPkg::stWr;
                end else if (rxReady) begin
                    req_o     = rdReq(`REG_RXDR);
                    nextRet   = pifPkg::stIn0;
                    nextState = pifPkg::stRd;
                end else if (!busy) begin
                    nextState = pifPkg::stStart;
                end else begin
                    req_o     = rdReq(`REG_SR);
                    nextRet   = pifPkg::stWaitTr;
                    nextState = pifPkg::stRd;
                end
            end
            pifPkg::stIn0: begin
                cmd_o.loadAddr  = (rxByte.f.tag == `PIF_TAG_ADDR);
                cmd_o.writeData = (rxByte.f.tag == `PIF_TAG_DATA);
                cmd_o.payload   = rxByte.f.payload;
                nextState       = pifPkg::stIdle;
            end
            pifPkg::stOut0: begin
                cmd_o.readDone = 1'b1;
                nextState      = pifPkg::stOut1;
            end
            pifPkg::stOut1: begin
                nextState = pifPkg::stIdle;
            end
            pifPkg::stWr, pifPkg::stRd: begin
                if (done_i) begin
                    nextState = retState;
                end
            end
            default: begin
                nextState = pifPkg::stStart;
            end
        endcase
    end

    // --------------------
    // state and decoded flags
    // --------------------

    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            state      <= pifPkg::stStart;
            retState   <= pifPkg::stStart;
            busy       <= 1'b0;
            txReady    <= 1'b0;
            rxReady    <= 1'b0;
            lastNak    <= 1'b0;
            rdIsStatus <= 1'b0;
            rxByte     <= '0;
        end else begin
            state    <= nextState;
            retState <= nextRet;
            if (req_o.go && !req_o.we) begin
                rdIsStatus <= (req_o.adr == `REG_SR);
            end
            if ((state == pifPkg::stRd) && done_i) begin
                if (rdIsStatus) begin
                    busy    <= status.busy;
                    txReady <= status.busy & status.trrdy & status.srw & ~status.tip;
                    rxReady <= status.busy & status.trrdy & ~status.srw;
                    lastNak <= status.busy & status.rarc & status.srw & status.troe;
                end else begin
                    rxByte.raw <= rdata_i;
                end
            end
        end
    end

    // --------------------
    // checks
    // --------------------

    oneCmdStrobe: assert property (
        @(posedge xclk) disable iff (!sys_rst)
        $onehot0({cmd_o.loadAddr, cmd_o.writeData, cmd_o.readDone})
    );

    // the engine only reports done for a cycle we are waiting on
    doneOnlyWhenWaiting: assert property (
        @(posedge xclk) disable iff (!sys_rst)
        done_i |-> (state inside {pifPkg::stWr, pifPkg::stRd})
    );

endmodule

`default_nettype wire

//--- source/pifPortCtl.sv
`timescale 1ns/1ps
`default_nettype none

`include "pifBridge_cfg.svh"

module pifPortCtl (
    input  wire                        xclk,
    input  wire                        sys_rst,
    input  pifPkg::pifCmd_t            cmd_i,
    output logic                       pWr_o,
    output logic [`PIF_ADDR_W-1:0]     prwa_o,
    output logic                       rdFinished_o,
    output logic [`PIF_SUBA_W-1:0]     prdSubA_o,
    output logic [`PIF_DATA_BITS-1:0]  pd_o
);

    // first stage, updated straight from the command strobes
    logic                      pWrReg;
    logic                      rdFinReg;
    logic [`PIF_ADDR_W-1:0]    rwAddr;
    logic [`PIF_SUBA_W-1:0]    rdSubA;
    logic [`PIF_DATA_BITS-1:0] pdReg;

    // --------------------
    // command stage
    // --------------------

    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            pWrReg   <= 1'b0;
            rdFinReg <= 1'b0;
            rwAddr   <= '0;
            rdSubA   <= '0;
            pdReg    <= '0;
        end else begin
            pWrReg   <= cmd_i.writeData;
            rdFinReg <= cmd_i.readDone;

            // new address restarts the read sequence
            if (cmd_i.loadAddr) begin
                rwAddr <= cmd_i.payload[`PIF_ADDR_W-1:0];
                rdSubA <= '0;
            end else if (cmd_i.readDone) begin
                // next read sub-address
                if (rdSubA == `PIF_SUBA_MAX) begin
                    rdSubA <= '0;
                end else begin
                    rdSubA <= rdSubA + 1'b1;
                end
            end

            if (cmd_i.writeData) begin
                pdReg <= cmd_i.payload;
            end
        end
    end

    // --------------------
    // output stage
    // --------------------

    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            pWr_o        <= 1'b0;
            prwa_o       <= '0;
            rdFinished_o <= 1'b0;
            prdSubA_o    <= '0;
            pd_o         <= '0;
        end else begin
            pWr_o        <= pWrReg;
            prwa_o       <= rwAddr;
            rdFinished_o <= rdFinReg;
            prdSubA_o    <= rdSubA;
            pd_o         <= pdReg;
        end
    end

endmodule

`default_nettype wire

//--- source/pifBridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "pifBridge_cfg.svh"

module pifBridge (
    input  wire                       xclk,
    input  wire                       sys_rst,
    input  wire [7:0]                 xo_i,
    // wishbone master towards the slave block
    output wire                       wbCyc_o,
    output wire                       wbStb_o,
    output wire                       wbWe_o,
    output wire [7:0]                 wbAdr_o,
    output wire [7:0]                 wbDat_o,
    input  wire                       wbAck_i,
    input  wire [7:0]                 wbDat_i,
    // parallel register port
    output wire                       pWr_o,
    output wire [`PIF_ADDR_W-1:0]     prwa_o,
    output wire                       rdFinished_o,
    output wire [`PIF_SUBA_W-1:0]     prdSubA_o,
    output wire [`PIF_DATA_BITS-1:0]  pd_o
);

    wire pifPkg::wbReq_t  req;
    wire pifPkg::pifCmd_t cmd;
    wire                  done;
    wire [7:0]            rdata;

    efbSequencer uSeq (
        .xclk    (xclk),
        .sys_rst (sys_rst),
        .done_i  (done),
        .rdata_i (rdata),
        .xo_i    (xo_i),
        .req_o   (req),
        .cmd_o   (cmd)
    );

    wbCycleEngine uWb (
        .xclk    (xclk),
        .sys_rst (sys_rst),
        .req_i   (req),
        .wbAck_i (wbAck_i),
        .wbDat_i (wbDat_i),
        .wbCyc_o (wbCyc_o),
        .wbStb_o (wbStb_o),
        .wbWe_o  (wbWe_o),
        .wbAdr_o (wbAdr_o),
        .wbDat_o (wbDat_o),
        .done_o  (done),
        .rdata_o (rdata)
    );

    pifPortCtl uPort (
        .xclk         (xclk),
        .sys_rst      (sys_rst),
        .cmd_i        (cmd),
        .pWr_o        (pWr_o),
        .prwa_o       (prwa_o),
        .rdFinished_o (rdFinished_o),
        .prdSubA_o    (prdSubA_o),
        .pd_o         (pd_o)
    );

endmodule

`default_nettype wire

//--- verification/pifBridgeChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "pifBridge_cfg.svh"

module pifBridgeChecker (
    input  wire                       xclk,
    input  wire                       sys_rst,
    // DUT ports under watch
    input  wire                       wbCyc_i,
    input  wire                       wbStb_i,
    input  wire                       wbWe_i,
    input  wire [7:0]                 wbAdr_i,
    input  wire [7:0]                 wbDat_i,
    input  wire                       wbAck_i,
    input  wire                       pWr_i,
    input  wire [`PIF_ADDR_W-1:0]     prwa_i,
    input  wire                       rdFinished_i,
    input  wire [`PIF_SUBA_W-1:0]     prdSubA_i,
    input  wire [`PIF_DATA_BITS-1:0]  pd_i,
    // expected values of the script line being served
    input  wire [15:0]                line_i,
    input  wire                       expWe_i,
    input  wire [7:0]                 expAdr_i,
    input  wire [7:0]                 expDat_i,
    input  wire [`PIF_ADDR_W-1:0]     expPrwa_i,
    input  wire [`PIF_SUBA_W-1:0]     expSubA_i,
    input  wire [`PIF_DATA_BITS-1:0]  expPd_i,
    input  wire [7:0]                 expWrCnt_i,
    input  wire [7:0]                 expFinCnt_i,
    output logic [15:0]               errCount_o
);

    // pulses seen on the parallel port so far
    logic [7:0] wrCount;
    logic [7:0] finCount;

    task automatic compareValue(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED line %0d %s: got 0x%0h, expected 0x%0h",
                     line_i + 1, name, got, exp);
            errCount_o = errCount_o + 1'b1;
        end
    endtask

    initial begin
        errCount_o = '0;
        wrCount    = '0;
        finCount   = '0;
    end

    // --------------------
    // sampling
    // --------------------

    always @(posedge xclk) begin
        if (!sys_rst) begin
            wrCount  = '0;
            finCount = '0;
            compareValue("bus outputs in reset",
                         {wbCyc_i, wbStb_i, wbWe_i, wbAdr_i, wbDat_i}, '0);
            compareValue("port outputs in reset",
                         {pWr_i, prwa_i, rdFinished_i, prdSubA_i, pd_i}, '0);
        end else begin
            if (pWr_i) begin
                wrCount = wrCount + 1'b1;
                // payload shows together with the write strobe
                compareValue("pd_o", pd_i, expPd_i);
            end
            if (rdFinished_i) begin
                finCount = finCount + 1'b1;
                // sub-address steps together with the finished strobe
                compareValue("prdSubA_o", prdSubA_i, expSubA_i);
            end
            // one access per script line, judged at its ack
            if (wbCyc_i && wbAck_i) begin
                compareValue("wbStb_o", wbStb_i, 1'b1);
                compareValue("wbWe_o", wbWe_i, expWe_i);
                compareValue("wbAdr_o", wbAdr_i, expAdr_i);
                if (expWe_i) begin
                    compareValue("wbDat_o", wbDat_i, expDat_i);
                end
                compareValue("prwa_o", prwa_i, expPrwa_i);
                compareValue("prdSubA_o", prdSubA_i, expSubA_i);
                compareValue("pd_o", pd_i, expPd_i);
                compareValue("pWr_o pulse count", wrCount, expWrCnt_i);
                compareValue("rdFinished_o pulse count", finCount, expFinCnt_i);
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/pifBridgeTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pifBridge_cfg.svh"

module pifBridgeTb;

    localparam int maxLines  = 64;
    localparam int waitLimit = 200;

    logic       xclk;
    logic       sys_rst;
    logic [7:0] xo;
    logic       wbAck;
    logic [7:0] wbRdat;

    wire                      wbCyc;
    wire                      wbStb;
    wire                      wbWe;
    wire [7:0]                wbAdr;
    wire [7:0]                wbWdat;
    wire                      pWr;
    wire [`PIF_ADDR_W-1:0]    prwa;
    wire                      rdFinished;
    wire [`PIF_SUBA_W-1:0]    prdSubA;
    wire [`PIF_DATA_BITS-1:0] pd;
    wire [15:0]               checkErrors;

    // one entry per expected bus access
    logic                      scrWe     [maxLines];
    logic [7:0]                scrAdr    [maxLines];
    logic [7:0]                scrDat    [maxLines];
    logic [7:0]                scrXo     [maxLines];
    logic [`PIF_ADDR_W-1:0]    scrPrwa   [maxLines];
    logic [`PIF_SUBA_W-1:0]    scrSubA   [maxLines];
    logic [`PIF_DATA_BITS-1:0] scrPd     [maxLines];
    logic [7:0]                scrWrCnt  [maxLines];
    logic [7:0]                scrFinCnt [maxLines];

    int          numLines;
    int          lineIdx;
    int          otherErrors;
    logic        timedOut;
    logic [31:0] rngState;

    always #2 xclk = ~xclk;

    pifBridge DUT (
        .xclk (xclk), .sys_rst (sys_rst), .xo_i (xo),
        .wbCyc_o (wbCyc), .wbStb_o (wbStb), .wbWe_o (wbWe),
        .wbAdr_o (wbAdr), .wbDat_o (wbWdat), .wbAck_i (wbAck), .wbDat_i (wbRdat),
        .pWr_o (pWr), .prwa_o (prwa), .rdFinished_o (rdFinished),
        .prdSubA_o (prdSubA), .pd_o (pd)
    );

    pifBridgeChecker uChecker (
        .xclk (xclk), .sys_rst (sys_rst),
        .wbCyc_i (wbCyc), .wbStb_i (wbStb), .wbWe_i (wbWe),
        .wbAdr_i (wbAdr), .wbDat_i (wbWdat), .wbAck_i (wbAck),
        .pWr_i (pWr), .prwa_i (prwa), .rdFinished_i (rdFinished),
        .prdSubA_i (prdSubA), .pd_i (pd),
        .line_i (lineIdx[15:0]), .expWe_i (scrWe[lineIdx]),
        .expAdr_i (scrAdr[lineIdx]), .expDat_i (scrDat[lineIdx]),
        .expPrwa_i (scrPrwa[lineIdx]), .expSubA_i (scrSubA[lineIdx]),
        .expPd_i (scrPd[lineIdx]), .expWrCnt_i (scrWrCnt[lineIdx]),
        .expFinCnt_i (scrFinCnt[lineIdx]), .errCount_o (checkErrors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // --------------------
    // test data
    // --------------------

    task automatic loadScript();
        int    fd;
        int    n;
        int    cWe, cAdr, cDat, cXo, cPrwa, cSubA, cPd, cWr, cFin;
        string text;
        fd = $fopen("verification/pifBridge_testdata.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open verification/pifBridge_testdata.txt");
            otherErrors++;
            return;
        end
        while (!$feof(fd) && numLines < maxLines) begin
            text = "";
            n = $fgets(text, fd);
            // blank lines and column notes carry no access
            if (n > 1 && text.getc(0) != "#") begin
                n = $sscanf(text, "%h %h %h %h %h %h %h %h %h",
                            cWe, cAdr, cDat, cXo, cPrwa, cSubA, cPd, cWr, cFin);
                if (n != 9) begin
                    $display("error: malformed test data line: %s", text);
                    otherErrors++;
                end else begin
                    scrWe[numLines]     = cWe[0];
                    scrAdr[numLines]    = cAdr[7:0];
                    scrDat[numLines]    = cDat[7:0];
                    scrXo[numLines]     = cXo[7:0];
                    scrPrwa[numLines]   = cPrwa[`PIF_ADDR_W-1:0];
                    scrSubA[numLines]   = cSubA[`PIF_SUBA_W-1:0];
                    scrPd[numLines]     = cPd[`PIF_DATA_BITS-1:0];
                    scrWrCnt[numLines]  = cWr[7:0];
                    scrFinCnt[numLines] = cFin[7:0];
                    numLines++;
                end
            end
        end
        $fclose(fd);
        if (numLines == 0) begin
            $display("error: the test data holds no bus accesses");
            otherErrors++;
        end
    endtask

    // --------------------
    // slave block model
    // --------------------

    // waits for the next cycle, acks it after 1 to 3 cycles
    task automatic serveAccess();
        int waited;
        int delay;
        waited = 0;
        xo     = scrXo[lineIdx];
        while (!wbCyc && waited < waitLimit) begin
            @(negedge xclk);
            waited++;
        end
        if (!wbCyc) begin
            $display("error: timeout, no bus cycle started for script line %0d", lineIdx + 1);
            otherErrors++;
            timedOut = 1'b1;
            return;
        end
        rngState = xorshift32(rngState);
        delay    = 1 + int'(rngState % 3);
        repeat (delay) @(negedge xclk);
        wbAck = 1'b1;
        if (wbWe) begin
            $display("slave block: write 0x%h to register 0x%h", wbWdat, wbAdr);
        end else begin
            wbRdat = scrDat[lineIdx];
        end
        @(negedge xclk);
        wbAck   = 1'b0;
        wbRdat  = 8'h00;
        lineIdx = lineIdx + 1;
    endtask

    initial begin
        xclk        = 1'b0;
        sys_rst     = 1'b1;
        xo          = 8'h00;
        wbAck       = 1'b0;
        wbRdat      = 8'h00;
        numLines    = 0;
        lineIdx     = 0;
        otherErrors = 0;
        timedOut    = 1'b0;
        rngState    = 32'd77981;
        loadScript();

        // async assert, release on a falling edge
        #1;
        sys_rst = 1'b0;
        repeat (16) @(posedge xclk);
        @(negedge xclk);
        sys_rst = 1'b1;

        while (lineIdx < numLines && !timedOut) begin
            serveAccess();
        end
        repeat (4) @(negedge xclk);

        $display("errors: %0d check, %0d other", checkErrors, otherErrors);
        if (checkErrors == 0 && otherErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/pifBridge_testdata.txt
# we adr data xo | expected at the ack: prwa subA pd pWr-count rdFinished-count (all hex)
# reads return data, writes must carry data, xo is driven while the line is served
1 41 04 00 0 0 00 00 00
0 45 40 00 0 0 00 00 00
0 45 40 00 0 0 00 00 00
0 45 00 00 0 0 00 00 00
0 47 3a 00 0 0 00 00 00
0 47 15 00 0 0 00 00 00
1 41 00 00 0 0 00 00 00
0 45 40 00 0 0 00 00 00
0 45 44 00 0 0 00 00 00
0 47 8b 00 0 0 00 00 00
0 45 44 00 b 0 00 00 00
0 47 6d 00 b 0 00 00 00
0 45 54 00 b 0 2d 01 00
1 44 a5 a5 b 0 2d 01 00
0 45 54 00 b 1 2d 01 01
1 44 5a 5a b 1 2d 01 01
0 45 54 00 b 2 2d 01 02
1 44 3c 3c b 2 2d 01 02
0 45 54 00 b 3 2d 01 03
1 44 c3 c3 b 3 2d 01 03
0 45 54 00 b 4 2d 01 04
1 44 0f 0f b 4 2d 01 04
0 45 54 00 b 5 2d 01 05
1 44 f0 f0 b 5 2d 01 05
0 45 54 00 b 0 2d 01 06
1 44 99 99 b 0 2d 01 06
0 45 44 00 b 1 2d 01 07
0 47 86 00 b 1 2d 01 07
0 45 44 00 6 0 2d 01 07
0 47 7f 00 6 0 2d 01 07
0 45 40 00 6 0 3f 02 07
0 45 72 00 6 0 3f 02 07
1 41 04 00 6 0 3f 02 07
0 45 00 00 6 0 3f 02 07
0 47 00 00 6 0 3f 02 07
0 47 00 00 6 0 3f 02 07
1 41 00 00 6 0 3f 02 07
0 45 40 00 6 0 3f 02 07
0 45 00 00 6 0 3f 02 07
1 41 04 00 6 0 3f 02 07

//--- flist.f
+incdir+source
source/pifPkg.sv
source/wbCycleEngine.sv
source/efbSequencer.sv
source/pifPortCtl.sv
source/pifBridge.sv
verification/pifBridgeChecker.sv
verification/pifBridgeTb.sv

//--- Bender.yml
package:
  name: pifBridge

sources:
  - include_dirs:
      - source
    files:
      - source/pifPkg.sv
      - source/wbCycleEngine.sv
      - source/efbSequencer.sv
      - source/pifPortCtl.sv
      - source/pifBridge.sv
      - target: test
        files:
          - verification/pifBridgeChecker.sv
          - verification/pifBridgeTb.sv
